//--- test/bch_syndrome_testdata.txt
// Columns: received word (15 bits, bit 14 sent first), expected S1, expected S3, error_free
// Syndromes are r(alpha^j) in GF(2^4) with x^4+x+1
0000 0 0 1
01D1 0 0 1
03A2 0 0 1
0E88 0 0 1
7440 0 0 1
7FFF 0 0 1
0273 0 0 1
1D10 0 0 1
0001 1 1 0
4000 9 F 0
01F1 6 1 0
7F7F B C 0
0688 E 8 0
03A6 4 C 0
7640 A F 0
0003 3 9 0
05D9 F B 0
1FFF 4 5 0
1263 C 3 0
1C50 9 2 0
0E0C F 0 0
0D44 4 7 0
0420 1 0 0
23A0 F 2 0
7FFE 1 1 0
41D0 8 E 0
2273 D A 0
1704 3 4 0

//--- list.f
src/bch_pkg.sv
src/syn_stream_if.sv
src/syn_frame_ctrl.sv
src/syn_remainder.sv
src/syn_expand.sv
src/bch_syndrome_top.sv
test/tb_clock_gen.sv
test/bch_syndrome_properties.sv
test/bch_syndrome_tb.sv

//--- test/bch_syndrome_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bch_syndrome_tb import bch_pkg::*; ();

	localparam int  BITS         = 3;
	localparam int  WORDS        = CODE_N / BITS;
	localparam int  NUM_VEC      = 28;  // Lines of data in the test file
	localparam int  RESET_CYCLES = 16;
	localparam int  MAX_GAP      = 3;
	localparam real CLK_PERIOD   = 4.0;
	// Each pass may also carry an abandoned partial frame and a run of stray words
	localparam int  FRAME_WORST    = 2 * WORDS * (MAX_GAP + 1) + WORDS;
	localparam int  TIMEOUT_CYCLES = RESET_CYCLES + 3 * NUM_VEC * FRAME_WORST + 100;

	logic            clk;
	logic            rst_n;
	logic            in_valid;
	logic            in_first;
	logic [BITS-1:0] in_data;
	logic            syn_valid;
	gf_elem_t        syn1;
	gf_elem_t        syn3;
	logic            error_free;

	logic [15:0] vec_mem [0:4*NUM_VEC-1];  // Word, S1, S3, error_free per vector
	integer      seed = 91;
	int          cycle = 0;                // Rising edges seen so far

	int       exp_cycle [$];
	gf_elem_t exp_s1 [$];
	gf_elem_t exp_s3 [$];
	logic     exp_ef [$];

	tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk (.clk(clk));

	bch_syndrome_top #(.BITS(BITS)) UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_first  (in_first),
		.in_data   (in_data),
		.syn_valid (syn_valid),
		.syn1      (syn1),
		.syn3      (syn3),
		.error_free(error_free)
	);

	bind bch_syndrome_top bch_syndrome_properties u_props (
		.clk       (clk),
		.rst_n     (rst_n),
		.syn_valid (syn_valid),
		.syn1      (syn1),
		.syn3      (syn3),
		.error_free(error_free)
	);

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopping at first error");
	endtask

	function automatic int random_gap();
		return $unsigned($random(seed)) % (MAX_GAP + 1);
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			in_valid <= 1'b0;
			in_first <= 1'b0;
			in_data  <= BITS'($random(seed));  // Junk that must be ignored
		end
	endtask

	task automatic drive_word(input logic [BITS-1:0] data, input logic first);
		@(posedge clk);
		in_valid <= 1'b1;
		in_first <= first;
		in_data  <= data;
	endtask

	// Sends the first num_words words of vector idx and books its result when complete
	task automatic send_frame(input int idx, input int num_words, input bit gaps);
		logic [CODE_N-1:0] cw;
		cw = vec_mem[4*idx][CODE_N-1:0];
		for (int w = 0; w < num_words; w++) begin
			if (gaps)
				idle_cycles(random_gap());
			drive_word(cw[CODE_N-1-w*BITS -: BITS], w == 0);
			if (w == WORDS - 1) begin
				// Sampled on the next edge, so syn_valid is seen high three counts on
				exp_cycle.push_back(cycle + 3);
				exp_s1.push_back(vec_mem[4*idx+1][GF_M-1:0]);
				exp_s3.push_back(vec_mem[4*idx+2][GF_M-1:0]);
				exp_ef.push_back(vec_mem[4*idx+3][0]);
			end
		end
	endtask

	task automatic check_result();
		int       want_cycle;
		gf_elem_t want_s1;
		gf_elem_t want_s3;
		logic     want_ef;
		assert (exp_cycle.size() > 0)
		else report_failure("syn_valid pulsed although no frame was outstanding");
		want_cycle = exp_cycle.pop_front();
		want_s1    = exp_s1.pop_front();
		want_s3    = exp_s3.pop_front();
		want_ef    = exp_ef.pop_front();
		assert (cycle == want_cycle)
		else report_failure($sformatf("syn_valid came at cycle %0d instead of cycle %0d",
			cycle, want_cycle));
		assert (syn1 === want_s1)
		else report_failure($sformatf("MISMATCH syn1: got 0x%h expected 0x%h", syn1, want_s1));
		assert (syn3 === want_s3)
		else report_failure($sformatf("MISMATCH syn3: got 0x%h expected 0x%h", syn3, want_s3));
		assert (error_free === want_ef)
		else report_failure($sformatf("MISMATCH error_free: got 0x%h expected 0x%h",
			error_free, want_ef));
	endtask

	// Outputs are settled at the falling edge
	always @(negedge clk) begin
		if (rst_n === 1'b1 && syn_valid === 1'b1)
			check_result();
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout after %0d cycles with %0d results still outstanding",
			TIMEOUT_CYCLES, exp_cycle.size());
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int cut;
		in_valid = 1'b0;
		in_first = 1'b0;
		in_data  = '0;
		rst_n    = 1'b0;
		$readmemh("test/bch_syndrome_testdata.txt", vec_mem);
		assert (!$isunknown(vec_mem[4*NUM_VEC-1]))
		else report_failure("the test data file is missing or shorter than expected");

		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		idle_cycles(2);

		// Back to back, the next frame opens on the cycle after a last word
		for (int i = 0; i < NUM_VEC; i++)
			send_frame(i, WORDS, 1'b0);
		idle_cycles(4);

		for (int i = 0; i < NUM_VEC; i++)
			send_frame(i, WORDS, 1'b1);
		idle_cycles(4);

		// A partial frame is cut short by in_first and must leave no trace
		for (int i = 0; i < NUM_VEC; i++) begin
			cut = 1 + $unsigned($random(seed)) % (WORDS - 1);
			send_frame((i + 7) % NUM_VEC, cut, 1'b1);
			send_frame(i, WORDS, 1'b1);
			if (i % 2 == 0) begin
				// Stray words outside any frame, as many as a whole frame holds
				for (int s = 0; s < WORDS; s++)
					drive_word(BITS'($random(seed)), 1'b0);
			end
		end
		idle_cycles(4);

		while (exp_cycle.size() != 0)
			@(posedge clk);
		idle_cycles(8);  // An extra pulse here would find the queue empty

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/bch_syndrome_properties.sv
`timescale 1ns/1ps
`default_nettype none

// Checks on the top-level result ports, attached to bch_syndrome_top
module bch_syndrome_properties import bch_pkg::*; (
	input wire logic     clk,
	input wire logic     rst_n,
	input wire logic     syn_valid,
	input wire gf_elem_t syn1,
	input wire gf_elem_t syn3,
	input wire logic     error_free
);

	// Each frame produces a single-cycle result strobe
	syn_valid_single_cycle: assert property (
		@(posedge clk) disable iff (!rst_n)
		syn_valid |=> !syn_valid
	) else $error("syn_valid stayed high for two consecutive cycles");

	// The result registers are cleared while reset is held
	syn_valid_low_in_reset: assert property (
		@(posedge clk)
		!rst_n |-> !syn_valid
	) else $error("syn_valid high while reset is asserted");

	error_free_means_zero: assert property (
		@(posedge clk) disable iff (!rst_n)
		error_free |-> (syn1 == '0 && syn3 == '0)
	) else $error("error_free set although a syndrome is nonzero");

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock for the testbench
module tb_clock_gen #(
	parameter real PERIOD_NS = 4.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2.0) clk = ~clk;
	end

endmodule

`default_nettype wire

//--- src/bch_syndrome_top.sv
`timescale 1ns/1ps
`default_nettype none

// Syndrome front end for BCH(15,7), producing S1, S3 and an error_free flag
module bch_syndrome_top import bch_pkg::*; #(
	parameter int BITS = 3  // Must divide CODE_N
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_valid,
	input  logic            in_first,
	input  logic [BITS-1:0] in_data,
	output logic            syn_valid,
	output gf_elem_t        syn1,
	output gf_elem_t        syn3,
	output logic            error_free
);

	gf_elem_t rem1;
	gf_elem_t rem3;

	syn_stream_if #(.BITS(BITS)) stream ();

	syn_frame_ctrl #(
		.BITS(BITS)
	) u_frame_ctrl (
		.clk     (clk),
		.rst_n   (rst_n),
		.in_valid(in_valid),
		.in_first(in_first),
		.in_data (in_data),
		.stream  (stream.ctrl)
	);

	// Remainder modulo the minimal polynomial of alpha
	syn_remainder #(
		.MIN_POLY(MIN_POLY_1),
		.BITS    (BITS)
	) u_rem1 (
		.clk      (clk),
		.rst_n    (rst_n),
		.stream   (stream.sink),
		.remainder(rem1)
	);

	// Remainder modulo the minimal polynomial of alpha^3
	syn_remainder #(
		.MIN_POLY(MIN_POLY_3),
		.BITS    (BITS)
	) u_rem3 (
		.clk      (clk),
		.rst_n    (rst_n),
		.stream   (stream.sink),
		.remainder(rem3)
	);

	syn_expand u_expand (
		.clk       (clk),
		.rst_n     (rst_n),
		.stream    (stream.done),
		.rem1      (rem1),
		.rem3      (rem3),
		.syn_valid (syn_valid),
		.syn1      (syn1),
		.syn3      (syn3),
		.error_free(error_free)
	);

endmodule

`default_nettype wire

//--- src/syn_expand.sv
`timescale 1ns/1ps
`default_nettype none

module syn_expand import bch_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	syn_stream_if.done stream,
	input  gf_elem_t   rem1,
	input  gf_elem_t   rem3,
	output logic       syn_valid,
	output gf_elem_t   syn1,
	output gf_elem_t   syn3,
	output logic       error_free
);

	// Evaluates b(x) at alpha^j
	// With j fixed each column is a constant, so this reduces to an XOR network
	function automatic gf_elem_t eval_at_power(input gf_elem_t b, input int unsigned j);
		gf_elem_t acc;
		acc = '0;
		for (int k = 0; k < GF_M; k++) begin
			if (b[k])
				acc ^= gf_pow_alpha(j * k);
		end
		return acc;
	endfunction

	gf_elem_t eval1;
	gf_elem_t eval3;
	logic     both_zero;

	assign eval1     = eval_at_power(rem1, 1);
	assign eval3     = eval_at_power(rem3, 3);
	assign both_zero = (eval1 == '0) && (eval3 == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			syn_valid  <= 1'b0;
			syn1       <= '0;
			syn3       <= '0;
			error_free <= 1'b0;
		end else begin
			syn_valid <= stream.frame_end;  // One cycle, since frame_end is itself a pulse
			if (stream.frame_end) begin
				// The remainders still hold the finished frame on this edge
				syn1       <= eval1;
				syn3       <= eval3;
				error_free <= both_zero;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/syn_remainder.sv
`timescale 1ns/1ps
`default_nettype none

// Running remainder of the received polynomial modulo one minimal polynomial
//
// Division is linear, so the next state splits into two independent parts.
// The old remainder shifted up by BITS degrees and reduced, and the new word
// reduced on its own starting from an empty register
module syn_remainder import bch_pkg::*; #(
	parameter min_poly_t MIN_POLY = MIN_POLY_1,
	parameter int        BITS     = 3
) (
	input  logic       clk,
	input  logic       rst_n,
	syn_stream_if.sink stream,
	output gf_elem_t   remainder
);

	localparam gf_elem_t FB_TAPS = MIN_POLY[GF_M-1:0];  // x^4 folds back onto these terms

	gf_elem_t lfsr;
	gf_elem_t in_stage [0:BITS];  // Word reduction, one stage per input bit
	gf_elem_t st_stage [0:BITS];  // State shifted with zero input
	logic     in_fb    [0:BITS-1];
	logic     st_fb    [0:BITS-1];
	gf_elem_t in_enc;
	gf_elem_t shift_enc;

	assign in_stage[0] = '0;
	assign st_stage[0] = lfsr;

	// Each stage multiplies by x and brings in the next lower-degree bit
	genvar i;
	generate
		for (i = 0; i < BITS; i++) begin : g_step
			assign in_fb[i] = in_stage[i][GF_M-1];
			assign st_fb[i] = st_stage[i][GF_M-1];

			assign in_stage[i+1] = {in_stage[i][GF_M-2:0], stream.data[BITS-1-i]}
				^ (in_fb[i] ? FB_TAPS : '0);
			assign st_stage[i+1] = {st_stage[i][GF_M-2:0], 1'b0}
				^ (st_fb[i] ? FB_TAPS : '0);
		end
	endgenerate

	assign in_enc    = in_stage[BITS];
	assign shift_enc = st_stage[BITS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lfsr <= '0;
		end else if (stream.ce) begin
			if (stream.start)
				lfsr <= in_enc;  // First word drops whatever the previous frame left
			else
				lfsr <= shift_enc ^ in_enc;
		end
	end

	// Holds between frames so the expander can sample it after the last word
	assign remainder = lfsr;

endmodule

`default_nettype wire

//--- src/syn_frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module syn_frame_ctrl import bch_pkg::*; #(
	parameter int BITS = 3
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_valid,
	input  logic            in_first,
	input  logic [BITS-1:0] in_data,
	syn_stream_if.ctrl      stream
);

	localparam int          WORDS    = CODE_N / BITS;
	localparam word_count_t LAST_IDX = word_count_t'(WORDS - 1);

	word_count_t word_count;  // Words accepted so far in the open frame
	logic        active;      // A frame is open and expects more words
	word_count_t word_idx;    // Position of the word on the input now
	logic        accept;
	logic        last_word;

	// A word only counts if it opens a frame or continues an open one
	assign accept    = in_valid & (in_first | active);
	assign word_idx  = in_first ? '0 : word_count;
	assign last_word = (word_idx == LAST_IDX);

	assign stream.ce    = accept;
	assign stream.start = in_valid & in_first;
	assign stream.data  = in_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			word_count       <= '0;
			active           <= 1'b0;
			stream.frame_end <= 1'b0;
		end else begin
			stream.frame_end <= accept & last_word;
			if (accept) begin
				if (last_word) begin
					word_count <= '0;
					active     <= 1'b0;  // Stray words now wait for the next in_first
				end else begin
					word_count <= word_idx + 1'b1;
					active     <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- src/syn_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// Per-word strobes from the frame control to the remainder units
interface syn_stream_if #(
	parameter int BITS = 3
);
	logic            ce;         // Word accepted on this edge
	logic            start;      // Accepted word is the first of a frame
	logic [BITS-1:0] data;       // Word payload, msb has the highest degree
	logic            frame_end;  // Registered pulse after the last word

	modport ctrl (
		output ce,
		output start,
		output data,
		output frame_end
	);

	modport sink (
		input ce,
		input start,
		input data
	);

	modport done (
		input frame_end
	);

endinterface

`default_nettype wire

//--- src/bch_pkg.sv
`default_nettype none

package bch_pkg;

	// GF(2^4) built on x^4+x+1, code length 2^4-1
	localparam int GF_M   = 4;
	localparam int CODE_N = 15;

	typedef logic [GF_M-1:0] gf_elem_t;   // Field element, bit k is the alpha^k coefficient
	typedef logic [GF_M:0]   min_poly_t;  // Minimal polynomial including the x^4 term
	typedef logic [3:0]      word_count_t;

	// Minimal polynomials of alpha and alpha^3
	localparam min_poly_t MIN_POLY_1 = 5'b10011;  // x^4+x+1
	localparam min_poly_t MIN_POLY_3 = 5'b11111;  // x^4+x^3+x^2+x+1

	localparam gf_elem_t GF_ONE   = 4'b0001;
	localparam gf_elem_t GF_ALPHA = 4'b0010;

	// Shift-and-add multiply, reduced by the primitive polynomial after each shift
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t x;
		acc = '0;
		x = a;
		for (int i = 0; i < GF_M; i++) begin
			if (b[i])
				acc ^= x;
			x = {x[GF_M-2:0], 1'b0} ^ (x[GF_M-1] ? MIN_POLY_1[GF_M-1:0] : '0);
		end
		return acc;
	endfunction

	// Powers of alpha repeat every CODE_N steps
	function automatic gf_elem_t gf_pow_alpha(input int unsigned n);
		gf_elem_t r;
		int unsigned e;
		r = GF_ONE;
		e = n % CODE_N;
		// Fixed loop bound keeps this usable in hardware as well as for constants
		for (int i = 0; i < CODE_N; i++) begin
			if (i < e)
				r = gf_mul(r, GF_ALPHA);
		end
		return r;
	endfunction

endpackage

`default_nettype wire
